// File: src/asymBuffer_config.svh
`ifndef ASYM_BUFFER_CONFIG_SVH
`define ASYM_BUFFER_CONFIG_SVH

// Byte address width, 256 bytes in total
`define ASYM_ADDR_W 8

// Host side word and stream side byte
`define ASYM_WIDE_W 32
`define ASYM_NARROW_W 8

// Wide over narrow gives the number of RAM blocks
`define ASYM_LANES 4
`define ASYM_LANE_W 2

// Burst length counts 0 up to a full 256 byte sweep
`define ASYM_LEN_W 9

`endif

// File: src/asymBufferPkg.sv
`include "asymBuffer_config.svh"

package asymBufferPkg;

   typedef logic [`ASYM_WIDE_W-1:0] wideWord_t;
   typedef logic [`ASYM_NARROW_W-1:0] narrowByte_t;
   typedef logic [`ASYM_ADDR_W-1:0] byteAddr_t;
   typedef logic [`ASYM_LEN_W-1:0] burstLen_t;

   // Burst direction on the narrow port
   typedef enum logic {
      opRead,
      opWrite
   } streamOp_t;

   typedef enum logic [1:0] {
      stIdle,
      stWrite,
      stRead
   } streamState_t;

endpackage

// File: src/dpRam.sv
`timescale 1ns/1ps

module dpRam #(
   parameter int dataW = 8,
   parameter int addrW = 6
) (
   input  logic             clk,
   input  logic             enA,
   input  logic             weA,
   input  logic [addrW-1:0] addrA,
   input  logic [dataW-1:0] dinA,
   output logic [dataW-1:0] doutA,
   input  logic             enB,
   input  logic             weB,
   input  logic [addrW-1:0] addrB,
   input  logic [dataW-1:0] dinB,
   output logic [dataW-1:0] doutB
);

   logic [dataW-1:0] mem [2**addrW];

   // Both write ports in one process, port B last on a collision
   always_ff @(posedge clk) begin
      if (enA && weA) begin
         mem[addrA] <= dinA;
      end
      if (enB && weB) begin
         mem[addrB] <= dinB;
      end
   end

   // Registered reads, a write cycle keeps the last read data
   always_ff @(posedge clk) begin
      if (enA && !weA) begin
         doutA <= mem[addrA];
      end
   end

   always_ff @(posedge clk) begin
      if (enB && !weB) begin
         doutB <= mem[addrB];
      end
   end

endmodule

// File: src/asymDpRam.sv
`timescale 1ns/1ps
`include "asymBuffer_config.svh"

module asymDpRam
   import asymBufferPkg::*;
(
   input  logic        clk,
   input  logic        rstN,
   input  logic        enA,
   input  logic        weA,
   input  byteAddr_t   addrA,
   input  wideWord_t   dinA,
   output wideWord_t   doutA,
   input  logic        enB,
   input  logic        weB,
   input  byteAddr_t   addrB,
   input  narrowByte_t dinB,
   output narrowByte_t doutB
);

   // Each block holds one byte lane of every word
   localparam int laneW = `ASYM_LANE_W;
   localparam int blockAddrW = `ASYM_ADDR_W - `ASYM_LANE_W;
   localparam int byteW = `ASYM_NARROW_W;

   // Word address shared by every lane
   logic [blockAddrW-1:0] wordAddrA;
   logic [blockAddrW-1:0] wordAddrB;

   // Lane index of the narrow access
   logic [laneW-1:0] laneB;
   logic [laneW-1:0] laneSel;

   // Per-block buses
   logic [`ASYM_LANES-1:0] blkEnB;
   narrowByte_t blkDinA [`ASYM_LANES];
   narrowByte_t blkOutA [`ASYM_LANES];
   narrowByte_t blkOutB [`ASYM_LANES];

   assign wordAddrA = addrA[`ASYM_ADDR_W-1:laneW];
   assign wordAddrB = addrB[`ASYM_ADDR_W-1:laneW];
   assign laneB = addrB[laneW-1:0];

   genvar g;
   generate
      for (g = 0; g < `ASYM_LANES; g++) begin : genLane
         // Wide port spreads its word, little-endian, one byte per block
         assign blkDinA[g] = dinA[g*byteW +: byteW];
         assign doutA[g*byteW +: byteW] = blkOutA[g];

         // Narrow port only touches the block its lane bits name
         assign blkEnB[g] = enB && (laneB == laneW'(g));

         dpRam #(
            .dataW(byteW),
            .addrW(blockAddrW)
         ) laneRam_i (
            .clk  (clk),
            .enA  (enA),
            .weA  (weA),
            .addrA(wordAddrA),
            .dinA (blkDinA[g]),
            .doutA(blkOutA[g]),
            .enB  (blkEnB[g]),
            .weB  (weB),
            .addrB(wordAddrB),
            .dinB (dinB),
            .doutB(blkOutB[g])
         );
      end
   endgenerate

   // Remember which lane was addressed so the output mux lines up
   // with the registered block data one cycle later
   always_ff @(posedge clk) begin
      if (!rstN) begin
         laneSel <= '0;
      end else if (enB) begin
         laneSel <= laneB;
      end
   end

   assign doutB = blkOutB[laneSel];

endmodule

// File: src/streamEngine.sv
`timescale 1ns/1ps

module streamEngine
   import asymBufferPkg::*;
(
   input  logic        clk,
   input  logic        rstN,
   input  logic        start,
   input  streamOp_t   op,
   input  byteAddr_t   baseAddr,
   input  burstLen_t   len,
   input  narrowByte_t byteIn,
   input  logic        byteInValid,
   output logic        busy,
   output narrowByte_t byteOut,
   output logic        byteOutValid,
   output logic        done,
   output logic        enB,
   output logic        weB,
   output byteAddr_t   addrB,
   output narrowByte_t dinB,
   input  narrowByte_t doutB
);

   streamState_t state;

   // Next byte address, wraps modulo 256
   byteAddr_t addrCnt;
   // Bytes still to move in this burst
   burstLen_t remaining;

   logic wrStrobe;
   logic rdIssue;
   logic lastByte;

   // Writes follow the producer, reads go out every cycle
   assign wrStrobe = (state == stWrite) && byteInValid;
   assign rdIssue = (state == stRead);
   assign lastByte = (remaining == burstLen_t'(1));

   assign busy = (state != stIdle);

   // Narrow port
   assign enB = wrStrobe || rdIssue;
   assign weB = wrStrobe;
   assign addrB = addrCnt;
   assign dinB = byteIn;

   // Read data comes straight from the RAM, qualified by byteOutValid
   assign byteOut = doutB;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= stIdle;
         addrCnt <= '0;
         remaining <= '0;
         done <= 1'b0;
         byteOutValid <= 1'b0;
      end else begin
         done <= 1'b0;
         // One issued read returns one cycle later
         byteOutValid <= rdIssue;

         case (state)
            stIdle: begin
               if (start) begin
                  if (len == '0) begin
                     // Nothing to move, report at once
                     done <= 1'b1;
                  end else begin
                     addrCnt <= baseAddr;
                     remaining <= len;
                     state <= (op == opWrite) ? stWrite : stRead;
                  end
               end
            end

            stWrite: begin
               if (byteInValid) begin
                  addrCnt <= addrCnt + 1'b1;
                  remaining <= remaining - 1'b1;
                  if (lastByte) begin
                     done <= 1'b1;
                     state <= stIdle;
                  end
               end
            end

            stRead: begin
               addrCnt <= addrCnt + 1'b1;
               remaining <= remaining - 1'b1;
               // done lands with the last byteOutValid
               if (lastByte) begin
                  done <= 1'b1;
                  state <= stIdle;
               end
            end

            default: begin
               state <= stIdle;
            end
         endcase
      end
   end

endmodule

// File: src/asymBufferTop.sv
`timescale 1ns/1ps

module asymBufferTop
   import asymBufferPkg::*;
(
   input  logic        clk,
   input  logic        rstN,
   // Host word port
   input  logic        enA,
   input  logic        weA,
   input  byteAddr_t   addrA,
   input  wideWord_t   dinA,
   output wideWord_t   doutA,
   // Stream control
   input  logic        start,
   input  streamOp_t   op,
   input  byteAddr_t   baseAddr,
   input  burstLen_t   len,
   input  narrowByte_t byteIn,
   input  logic        byteInValid,
   output logic        busy,
   output narrowByte_t byteOut,
   output logic        byteOutValid,
   output logic        done
);

   // Narrow port between the engine and the RAM
   logic        enB;
   logic        weB;
   byteAddr_t   addrB;
   narrowByte_t dinB;
   narrowByte_t doutB;

   asymDpRam asymDpRam_i (
      .clk  (clk),
      .rstN (rstN),
      .enA  (enA),
      .weA  (weA),
      .addrA(addrA),
      .dinA (dinA),
      .doutA(doutA),
      .enB  (enB),
      .weB  (weB),
      .addrB(addrB),
      .dinB (dinB),
      .doutB(doutB)
   );

   streamEngine streamEngine_i (
      .clk         (clk),
      .rstN        (rstN),
      .start       (start),
      .op          (op),
      .baseAddr    (baseAddr),
      .len         (len),
      .byteIn      (byteIn),
      .byteInValid (byteInValid),
      .busy        (busy),
      .byteOut     (byteOut),
      .byteOutValid(byteOutValid),
      .done        (done),
      .enB         (enB),
      .weB         (weB),
      .addrB       (addrB),
      .dinB        (dinB),
      .doutB       (doutB)
   );

endmodule

// File: verification/asymBufferTb.sv
`timescale 1ns/1ps

module asymBufferTb
   import asymBufferPkg::*;
();

   localparam int wordCount = 64;

   logic        clk;
   logic        rstN;
   logic        enA;
   logic        weA;
   byteAddr_t   addrA;
   wideWord_t   dinA;
   wideWord_t   doutA;
   logic        start;
   streamOp_t   op;
   byteAddr_t   baseAddr;
   burstLen_t   len;
   narrowByte_t byteIn;
   logic        byteInValid;
   logic        busy;
   narrowByte_t byteOut;
   logic        byteOutValid;
   logic        done;

   // One entry per stimulus line
   byte         cmdQ [$];
   logic [31:0] addrQ [$];
   logic [31:0] argQ [$];
   logic [31:0] dataQ [$];
   int          lineQ [$];

   // Per-burst data
   int          gaps [$];
   narrowByte_t wrBytes [$];
   narrowByte_t expBytes [$];
   wideWord_t   wordModel [wordCount];

   int     mismatchCount = 0;
   int     otherCount = 0;
   int     cycleCount = 0;
   int     cycleLimit = 0;
   logic   limitReady = 1'b0;
   integer seed;

   asymBufferTop asymBufferTop_i (
      .clk         (clk),
      .rstN        (rstN),
      .enA         (enA),
      .weA         (weA),
      .addrA       (addrA),
      .dinA        (dinA),
      .doutA       (doutA),
      .start       (start),
      .op          (op),
      .baseAddr    (baseAddr),
      .len         (len),
      .byteIn      (byteIn),
      .byteInValid (byteInValid),
      .busy        (busy),
      .byteOut     (byteOut),
      .byteOutValid(byteOutValid),
      .done        (done)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic finishRun();
      $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
      if (mismatchCount == 0 && otherCount == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   endtask

   // Watchdog armed once the stimulus length is known
   initial begin
      wait (limitReady);
      while (cycleCount <= cycleLimit) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      otherCount++;
      finishRun();
   end

   task automatic checkWord(input string name, input wideWord_t expected,
                            input wideWord_t actual);
      if (actual !== expected) begin
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
         mismatchCount++;
      end
   endtask

   task automatic checkByte(input string name, input narrowByte_t expected,
                            input narrowByte_t actual);
      if (actual !== expected) begin
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
         mismatchCount++;
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
         mismatchCount++;
      end
   endtask

   task automatic readStimulus();
      int fd;
      int lineNo;
      int got;
      string text;
      byte cmd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      fd = $fopen("verification/asymBuffer_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file");
         otherCount++;
         return;
      end
      lineNo = 0;
      while (!$feof(fd)) begin
         text = "";
         got = $fgets(text, fd);
         lineNo++;
         // Comments and blank lines carry no operation
         if (got > 1 && text.getc(0) != "#") begin
            got = $sscanf(text, "%c %h %h %h", cmd, a, b, c);
            if (got == 4) begin
               cmdQ.push_back(cmd);
               addrQ.push_back(a);
               argQ.push_back(b);
               dataQ.push_back(c);
               lineQ.push_back(lineNo);
            end else begin
               $display("Stimulus line %0d could not be parsed", lineNo);
               otherCount++;
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic hostWrite(input byteAddr_t addr, input wideWord_t word);
      @(posedge clk);
      enA <= 1'b1;
      weA <= 1'b1;
      addrA <= addr;
      dinA <= word;
      @(posedge clk);
      enA <= 1'b0;
      weA <= 1'b0;
   endtask

   task automatic hostRead(input string name, input byteAddr_t addr, input wideWord_t expected);
      @(posedge clk);
      enA <= 1'b1;
      weA <= 1'b0;
      addrA <= addr;
      @(posedge clk);
      enA <= 1'b0;
      @(negedge clk);
      checkWord(name, expected, doutA);
   endtask

   task automatic streamWrite(input string name, input byteAddr_t base, input burstLen_t n);
      @(posedge clk);
      start <= 1'b1;
      op <= opWrite;
      baseAddr <= base;
      len <= n;
      @(posedge clk);
      start <= 1'b0;
      // busy rises the cycle after start is taken
      @(negedge clk);
      if (n != '0) begin
         checkFlag({name, " busy"}, 1'b1, busy);
      end
      foreach (wrBytes[k]) begin
         repeat (gaps[k]) begin
            @(posedge clk);
            byteInValid <= 1'b0;
         end
         @(posedge clk);
         byteInValid <= 1'b1;
         byteIn <= wrBytes[k];
      end
      @(posedge clk);
      byteInValid <= 1'b0;
      // done and the fall of busy come one cycle after the last byte
      @(negedge clk);
      if (done !== 1'b1) begin
         $display("%s: done did not follow the last byte", name);
         otherCount++;
      end
      checkFlag({name, " busy"}, 1'b0, busy);
   endtask

   task automatic streamRead(input string name, input byteAddr_t base, input burstLen_t n,
                             input logic stray);
      int nBytes;
      int waited;
      int got;
      logic finished;
      nBytes = int'(n);
      @(posedge clk);
      start <= 1'b1;
      op <= opRead;
      baseAddr <= base;
      len <= n;
      @(posedge clk);
      start <= 1'b0;
      waited = 0;
      got = 0;
      finished = 1'b0;
      while (!finished) begin
         @(negedge clk);
         // busy stays high until the cycle of the last byte
         if (nBytes > 0) begin
            checkFlag({name, " busy"}, logic'(waited < nBytes), busy);
         end
         if (byteOutValid === 1'b1) begin
            if (got < expBytes.size()) begin
               checkByte($sformatf("%s byte %0d", name, got), expBytes[got], byteOut);
            end else begin
               $display("%s: byte %0d arrived past the end of the burst", name, got);
               otherCount++;
            end
            got++;
         end
         if (done === 1'b1) begin
            finished = 1'b1;
            // Last byte and done arrive n cycles after start is taken
            if (got != nBytes || waited != nBytes) begin
               $display("%s: done came after %0d bytes in cycle %0d, expected %0d and %0d",
                        name, got, waited, nBytes, nBytes);
               otherCount++;
            end
         end else if (waited > nBytes + 4) begin
            $display("%s: no done within %0d cycles of start", name, waited);
            otherCount++;
            finished = 1'b1;
         end
         if (!finished) begin
            @(posedge clk);
            waited++;
            // Start pulsed in the middle of the burst
            if (stray && waited == 2 && waited + 2 < nBytes) begin
               start <= 1'b1;
               op <= opWrite;
               baseAddr <= base + 8'h40;
               len <= burstLen_t'(3);
            end else begin
               start <= 1'b0;
            end
         end
      end
   endtask

   task automatic roundTrip(input string name, input byteAddr_t base, input burstLen_t n);
      int w;
      int i;
      byteAddr_t a;
      for (w = 0; w < wordCount; w++) begin
         wordModel[w] = $random(seed);
         hostWrite(byteAddr_t'(w * 4), wordModel[w]);
      end
      // Byte 4w+k is lane k of word w
      expBytes.delete();
      for (i = 0; i < int'(n); i++) begin
         a = base + byteAddr_t'(i);
         expBytes.push_back(wordModel[a[7:2]][8 * a[1:0] +: 8]);
      end
      streamRead(name, base, n, 1'b0);
   endtask

   initial begin
      int i;
      int k;
      string name;
      rstN = 1'b0;
      enA = 1'b0;
      weA = 1'b0;
      addrA = '0;
      dinA = '0;
      start = 1'b0;
      op = opRead;
      baseAddr = '0;
      len = '0;
      byteIn = '0;
      byteInValid = 1'b0;
      seed = 77900;
      readStimulus();

      // Doubled sum of startup, burst bytes and per-line margins
      cycleLimit = 16;
      foreach (cmdQ[j]) begin
         cycleLimit += 8;
         case (cmdQ[j])
            "S", "T": cycleLimit += int'(argQ[j]);
            "D": cycleLimit += int'(argQ[j]) + 1;
            "X": cycleLimit += int'(argQ[j]) + 2 * wordCount;
            default: cycleLimit += 2;
         endcase
      end
      cycleLimit = cycleLimit * 2;
      limitReady = 1'b1;

      repeat (16) @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      checkFlag("reset busy", 1'b0, busy);
      checkFlag("reset done", 1'b0, done);
      checkFlag("reset byteOutValid", 1'b0, byteOutValid);

      i = 0;
      while (i < cmdQ.size()) begin
         name = $sformatf("line %0d %c", lineQ[i], cmdQ[i]);
         case (cmdQ[i])
            "W": hostWrite(addrQ[i][7:0], argQ[i]);
            "R": hostRead(name, addrQ[i][7:0], dataQ[i]);
            "S", "T": begin
               gaps.delete();
               wrBytes.delete();
               expBytes.delete();
               for (k = 1; k <= int'(argQ[i]); k++) begin
                  if (i + k >= cmdQ.size() || (cmdQ[i + k] != "D" && cmdQ[i + k] != "E")) begin
                     $display("%s: data line %0d of the burst is missing", name, k);
                     otherCount++;
                  end else begin
                     gaps.push_back(int'(argQ[i + k]));
                     wrBytes.push_back(dataQ[i + k][7:0]);
                     expBytes.push_back(dataQ[i + k][7:0]);
                  end
               end
               if (cmdQ[i] == "S") begin
                  streamWrite(name, addrQ[i][7:0], argQ[i][8:0]);
               end else begin
                  streamRead(name, addrQ[i][7:0], argQ[i][8:0], dataQ[i][0]);
               end
               i += int'(argQ[i]);
            end
            "X": roundTrip(name, addrQ[i][7:0], argQ[i][8:0]);
            default: begin
               $display("%s: unknown command", name);
               otherCount++;
            end
         endcase
         i++;
      end
      repeat (4) @(posedge clk);
      finishRun();
   end

endmodule

// File: verification/asymBuffer_stim.txt
# Columns, all hex: cmd addr arg data. W addr word 0, R addr 0 expectedWord
# S base len 0 then D 0 gap byte, T base len strayStart then E 0 0 byte, X base len 0
W 00 11223344 0
W 04 a5a55a5a 0
W 10 deadbeef 0
W fc 01020304 0
R 00 0 11223344
R 06 0 a5a55a5a
R 13 0 deadbeef
R fc 0 01020304
T 10 4 0
E 0 0 ef
E 0 0 be
E 0 0 ad
E 0 0 de
T 04 4 0
E 0 0 5a
E 0 0 5a
E 0 0 a5
E 0 0 a5
S 20 8 0
D 0 0 10
D 0 2 21
D 0 0 32
D 0 1 43
D 0 3 54
D 0 0 65
D 0 0 76
D 0 2 87
R 20 0 43322110
R 24 0 87766554
W 3c 0 0
W 40 0 0
S 3e 3 0
D 0 1 c1
D 0 0 c2
D 0 2 c3
R 3c 0 c2c10000
R 40 0 000000c3
T fe 6 1
E 0 0 02
E 0 0 01
E 0 0 44
E 0 0 33
E 0 0 22
E 0 0 11
T 40 0 0
X 00 100 0
X 80 40 0

// File: sim.f
+incdir+src
src/asymBufferPkg.sv
src/dpRam.sv
src/asymDpRam.sv
src/streamEngine.sv
src/asymBufferTop.sv
verification/asymBufferTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build the asymBuffer testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simBin=asymBufferSim

verilator --binary --timing -Wno-fatal -f sim.f --top-module asymBufferTb \
   --Mdir "$buildDir" -o "$simBin"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

simOutput=$("./$buildDir/$simBin")
simStatus=$?
echo "$simOutput"

if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if echo "$simOutput" | grep -qx "RESULT: PASS"; then
   exit 0
else
   exit 1
fi
